/* hw/fft_pkg.sv */
package fft_pkg;

	localparam int WORD_W   = 16;
	localparam int FRAC_W   = 8;
	localparam int N_POINTS = 16;
	localparam int N_STAGES = 4;
	localparam int N_BFLY   = N_POINTS / 2;
	localparam int STAGE_W  = 2;

	// cycle budget of one stage and one frame
	localparam int BFLY_LAT     = 2;
	localparam int STAGE_CYCLES = BFLY_LAT;
	localparam int FRAME_CYCLES = N_STAGES * STAGE_CYCLES;

	typedef logic signed [WORD_W-1:0] word_t;
	typedef logic [STAGE_W-1:0] stage_t;
	typedef logic [$clog2(STAGE_CYCLES)-1:0] stage_cnt_t;
	typedef logic [$clog2(N_POINTS)-1:0] point_idx_t;
	typedef logic [$clog2(N_BFLY)-1:0] tw_idx_t;

	typedef struct packed {
		word_t re;
		word_t im;
	} cplx_t;

	//////////////////////////////
	// W16^k, Q8.8
	//////////////////////////////
	localparam word_t TWIDDLE_RE [N_BFLY] = '{
		16'sd256, 16'sd237, 16'sd181, 16'sd98,
		16'sd0, -16'sd98, -16'sd181, -16'sd237
	};
	localparam word_t TWIDDLE_IM [N_BFLY] = '{
		16'sd0, -16'sd98, -16'sd181, -16'sd237,
		-16'sd256, -16'sd237, -16'sd181, -16'sd98
	};

	// distance between the two points of a butterfly
	function automatic point_idx_t span(input stage_t s);
		return point_idx_t'(1) << s;
	endfunction

	// upper point of butterfly k, group bits moved up by one
	function automatic point_idx_t top_idx(input stage_t s, input int unsigned k);
		point_idx_t kk;
		point_idx_t low;
		kk = point_idx_t'(k);
		low = span(s) - 1'b1;
		return ((kk & ~low) << 1) | (kk & low);
	endfunction

	function automatic tw_idx_t twiddle_idx(input stage_t s, input int unsigned k);
		point_idx_t j;
		j = point_idx_t'(k) & (span(s) - 1'b1);
		j = j << (stage_t'(N_STAGES - 1) - s);
		return j[$bits(tw_idx_t)-1:0];
	endfunction

	function automatic point_idx_t bitrev(input point_idx_t v);
		point_idx_t r;
		for (int i = 0; i < $bits(point_idx_t); i++) begin
			r[i] = v[$bits(point_idx_t)-1-i];
		end
		return r;
	endfunction

endpackage

/* hw/bfly_if.sv */
`timescale 1ns/1ps

// operands and results of a single butterfly
interface bfly_if;

	fft_pkg::cplx_t a;
	fft_pkg::cplx_t b;
	// twiddle for b
	fft_pkg::cplx_t w;

	// a + b*w and a - b*w
	fft_pkg::cplx_t x;
	fft_pkg::cplx_t y;

	modport router (
		output a,
		output b,
		output w
	);

	modport bfly (
		input  a,
		input  b,
		input  w,
		output x,
		output y
	);

	modport bank (
		input x,
		input y
	);

endinterface

/* hw/fft_control.sv */
`timescale 1ns/1ps

module fft_control (
	input  logic i_clk,
	input  logic i_rst_n,
	input  logic i_stage_end,
	output logic o_run,
	output fft_pkg::stage_t o_stage,
	output logic o_write,
	output logic o_last,
	output logic o_fft_done
);

	typedef enum logic {
		IDLE,
		RUN
	} state_t;

	state_t state;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state <= IDLE;
			o_stage <= '0;
			o_fft_done <= 1'b0;
		end else begin
			case (state)
				// free running, no start strobe
				IDLE: state <= RUN;
				RUN: state <= RUN;
				default: state <= IDLE;
			endcase

			if (o_write) begin
				if (o_last) begin
					o_stage <= '0;
				end else begin
					o_stage <= o_stage + 1'b1;
				end
			end

			// outputs are loaded on the last write, flag them one cycle later
			o_fft_done <= o_write && o_last;
		end
	end

	assign o_run = (state == RUN);
	assign o_write = o_run && i_stage_end;
	assign o_last = (o_stage == fft_pkg::stage_t'(fft_pkg::N_STAGES - 1));

	// frames are back to back, so a done pulse never stretches
	assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_fft_done |=> !o_fft_done);

endmodule

/* hw/stage_timer.sv */
`timescale 1ns/1ps

module stage_timer (
	input  logic i_clk,
	input  logic i_rst_n,
	input  logic i_run,
	output logic o_stage_end,
	output logic o_first
);

	fft_pkg::stage_cnt_t cnt;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			cnt <= '0;
		end else if (i_run) begin
			if (cnt == fft_pkg::stage_cnt_t'(fft_pkg::STAGE_CYCLES - 1)) begin
				cnt <= '0;
			end else begin
				cnt <= cnt + 1'b1;
			end
		end
	end

	assign o_first = i_run && (cnt == '0);
	// results settle BFLY_LAT-1 cycles after the operands
	assign o_stage_end = i_run && (cnt == fft_pkg::stage_cnt_t'(fft_pkg::BFLY_LAT - 1));

	// a stage end only while running, and always after that stage's first cycle
	assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_stage_end |-> i_run && $past(o_first, fft_pkg::BFLY_LAT - 1));

endmodule

/* hw/operand_router.sv */
`timescale 1ns/1ps

module operand_router (
	input  logic i_clk,
	input  logic i_rst_n,
	input  fft_pkg::stage_t i_stage,
	input  logic i_first,
	input  fft_pkg::cplx_t [fft_pkg::N_POINTS-1:0] i_samples,
	input  fft_pkg::cplx_t [fft_pkg::N_POINTS-1:0] i_work,
	bfly_if.router bf [fft_pkg::N_BFLY]
);

	fft_pkg::cplx_t [fft_pkg::N_BFLY-1:0] sel_a;
	fft_pkg::cplx_t [fft_pkg::N_BFLY-1:0] sel_b;
	fft_pkg::cplx_t [fft_pkg::N_BFLY-1:0] sel_w;

	fft_pkg::cplx_t [fft_pkg::N_BFLY-1:0] hold_a;
	fft_pkg::cplx_t [fft_pkg::N_BFLY-1:0] hold_b;
	fft_pkg::cplx_t [fft_pkg::N_BFLY-1:0] hold_w;

	//////////////////////////////
	// stage dependent selection
	//////////////////////////////
	always_comb begin
		fft_pkg::point_idx_t top;
		fft_pkg::point_idx_t bot;
		fft_pkg::tw_idx_t tw;
		for (int k = 0; k < fft_pkg::N_BFLY; k++) begin
			top = fft_pkg::top_idx(i_stage, k);
			bot = top + fft_pkg::span(i_stage);
			tw = fft_pkg::twiddle_idx(i_stage, k);
			if (i_stage == '0) begin
				// inputs enter in bit reversed order
				sel_a[k] = i_samples[fft_pkg::bitrev(top)];
				sel_b[k] = i_samples[fft_pkg::bitrev(bot)];
			end else begin
				sel_a[k] = i_work[top];
				sel_b[k] = i_work[bot];
			end
			sel_w[k].re = fft_pkg::TWIDDLE_RE[tw];
			sel_w[k].im = fft_pkg::TWIDDLE_IM[tw];
		end
	end

	// captured in the first cycle, the rest of the stage sees a frozen copy
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			hold_a <= '0;
			hold_b <= '0;
			hold_w <= '0;
		end else if (i_first) begin
			hold_a <= sel_a;
			hold_b <= sel_b;
			hold_w <= sel_w;
		end
	end

	for (genvar k = 0; k < fft_pkg::N_BFLY; k++) begin : g_drive
		assign bf[k].a = i_first ? sel_a[k] : hold_a[k];
		assign bf[k].b = i_first ? sel_b[k] : hold_b[k];
		assign bf[k].w = i_first ? sel_w[k] : hold_w[k];
	end

endmodule

/* hw/bfly_array.sv */
`timescale 1ns/1ps

module bfly_array (
	input  logic i_clk,
	input  logic i_rst_n,
	bfly_if.bfly bf [fft_pkg::N_BFLY]
);

	// Q8.8 product back to a word, upper bits dropped
	function automatic fft_pkg::word_t scale(input logic signed [31:0] m);
		logic signed [31:0] s;
		s = m >>> fft_pkg::FRAC_W;
		return s[fft_pkg::WORD_W-1:0];
	endfunction

	for (genvar k = 0; k < fft_pkg::N_BFLY; k++) begin : g_bfly
		logic signed [31:0] m_rr;
		logic signed [31:0] m_ii;
		logic signed [31:0] m_ri;
		logic signed [31:0] m_ir;
		fft_pkg::cplx_t p;
		fft_pkg::cplx_t p_q;
		fft_pkg::cplx_t a_q;
		fft_pkg::cplx_t x;
		fft_pkg::cplx_t y;

		//////////////////////////////
		// b * w
		//////////////////////////////
		assign m_rr = 32'(bf[k].b.re) * 32'(bf[k].w.re);
		assign m_ii = 32'(bf[k].b.im) * 32'(bf[k].w.im);
		assign m_ri = 32'(bf[k].b.re) * 32'(bf[k].w.im);
		assign m_ir = 32'(bf[k].b.im) * 32'(bf[k].w.re);

		// each partial product is scaled on its own
		assign p.re = scale(m_rr) - scale(m_ii);
		assign p.im = scale(m_ri) + scale(m_ir);

		// product stage, a travels alongside
		always_ff @(posedge i_clk or negedge i_rst_n) begin
			if (!i_rst_n) begin
				p_q <= '0;
				a_q <= '0;
			end else begin
				p_q <= p;
				a_q <= bf[k].a;
			end
		end

		// sum and difference, wrapping
		// second stage register is the bank write at stage end
		assign x.re = a_q.re + p_q.re;
		assign x.im = a_q.im + p_q.im;
		assign y.re = a_q.re - p_q.re;
		assign y.im = a_q.im - p_q.im;

		assign bf[k].x = x;
		assign bf[k].y = y;
	end

endmodule

/* hw/result_bank.sv */
`timescale 1ns/1ps

module result_bank (
	input  logic i_clk,
	input  logic i_rst_n,
	input  fft_pkg::stage_t i_stage,
	input  logic i_write,
	input  logic i_last,
	bfly_if.bank bf [fft_pkg::N_BFLY],
	output fft_pkg::cplx_t [fft_pkg::N_POINTS-1:0] o_work,
	output fft_pkg::word_t [fft_pkg::N_POINTS-1:0] o_re,
	output fft_pkg::word_t [fft_pkg::N_POINTS-1:0] o_im
);

	fft_pkg::cplx_t x_res [fft_pkg::N_BFLY];
	fft_pkg::cplx_t y_res [fft_pkg::N_BFLY];

	fft_pkg::cplx_t [fft_pkg::N_POINTS-1:0] work_d;
	fft_pkg::cplx_t [fft_pkg::N_POINTS-1:0] work_q;
	fft_pkg::cplx_t [fft_pkg::N_POINTS-1:0] out_q;

	for (genvar k = 0; k < fft_pkg::N_BFLY; k++) begin : g_tap
		assign x_res[k] = bf[k].x;
		assign y_res[k] = bf[k].y;
	end

	// scatter results back to their point positions
	always_comb begin
		fft_pkg::point_idx_t top;
		work_d = work_q;
		for (int k = 0; k < fft_pkg::N_BFLY; k++) begin
			top = fft_pkg::top_idx(i_stage, k);
			work_d[top] = x_res[k];
			work_d[top + fft_pkg::span(i_stage)] = y_res[k];
		end
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			work_q <= '0;
			out_q <= '0;
		end else if (i_write) begin
			work_q <= work_d;
			// finished bins, natural order
			if (i_last) begin
				out_q <= work_d;
			end
		end
	end

	assign o_work = work_q;

	for (genvar n = 0; n < fft_pkg::N_POINTS; n++) begin : g_out
		assign o_re[n] = out_q[n].re;
		assign o_im[n] = out_q[n].im;
	end

	// write needs a known stage, and the output copy only on the final one
	assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_write |-> !$isunknown(i_stage) &&
			(i_last == (i_stage == fft_pkg::stage_t'(fft_pkg::N_STAGES - 1))));

endmodule

/* hw/fft16_top.sv */
`timescale 1ns/1ps

module fft16_top (
	input  logic i_clk,
	input  logic i_rst_n,
	input  fft_pkg::word_t [fft_pkg::N_POINTS-1:0] i_re,
	input  fft_pkg::word_t [fft_pkg::N_POINTS-1:0] i_im,
	output fft_pkg::word_t [fft_pkg::N_POINTS-1:0] o_re,
	output fft_pkg::word_t [fft_pkg::N_POINTS-1:0] o_im,
	output logic o_fft_done
);

	fft_pkg::cplx_t [fft_pkg::N_POINTS-1:0] samples;
	fft_pkg::cplx_t [fft_pkg::N_POINTS-1:0] work;

	logic run;
	logic stage_end;
	logic first;
	logic write;
	logic last;
	fft_pkg::stage_t stage;

	bfly_if bf [fft_pkg::N_BFLY] ();

	for (genvar n = 0; n < fft_pkg::N_POINTS; n++) begin : g_pack
		assign samples[n].re = i_re[n];
		assign samples[n].im = i_im[n];
	end

	//////////////////////////////
	// sequencing
	//////////////////////////////
	fft_control u_control (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_stage_end (stage_end),
		.o_run       (run),
		.o_stage     (stage),
		.o_write     (write),
		.o_last      (last),
		.o_fft_done  (o_fft_done)
	);

	stage_timer u_timer (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_run       (run),
		.o_stage_end (stage_end),
		.o_first     (first)
	);

	//////////////////////////////
	// datapath
	//////////////////////////////
	operand_router u_router (
		.i_clk     (i_clk),
		.i_rst_n   (i_rst_n),
		.i_stage   (stage),
		.i_first   (first),
		.i_samples (samples),
		.i_work    (work),
		.bf        (bf)
	);

	bfly_array u_bfly (
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.bf      (bf)
	);

	result_bank u_bank (
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.i_stage (stage),
		.i_write (write),
		.i_last  (last),
		.bf      (bf),
		.o_work  (work),
		.o_re    (o_re),
		.o_im    (o_im)
	);

endmodule

/* testbench/fft_model.svh */
`ifndef FFT_MODEL_SVH
`define FFT_MODEL_SVH

// W16^k, Q8.8
localparam int TW_RE [8] = '{256, 237, 181, 98, 0, -98, -181, -237};
localparam int TW_IM [8] = '{0, -98, -181, -237, -256, -237, -181, -98};

int stim_re [16];
int stim_im [16];
int ref_re [16];
int ref_im [16];

// low 16 bits, sign extended
function automatic int wrap16(input int v);
	logic signed [15:0] t;
	t = v[15:0];
	return int'(t);
endfunction

// floor shift of the full product, then truncate
function automatic int qmul(input int b, input int w);
	return wrap16((b * w) >>> 8);
endfunction

function automatic int bit_reverse4(input int v);
	return ((v & 1) << 3) | ((v & 2) << 1) | ((v & 4) >> 1) | ((v & 8) >> 3);
endfunction

task automatic compute_reference;
	int wr [16];
	int wi [16];
	int h;
	int top;
	int bot;
	int tw;
	int pr;
	int pim;
	for (int n = 0; n < 16; n++) begin
		wr[n] = stim_re[bit_reverse4(n)];
		wi[n] = stim_im[bit_reverse4(n)];
	end
	for (int s = 0; s < 4; s++) begin
		h = 1 << s;
		for (int k = 0; k < 8; k++) begin
			top = (k / h) * 2 * h + (k % h);
			bot = top + h;
			tw = (k % h) * (8 / h);
			pr = wrap16(qmul(wr[bot], TW_RE[tw]) - qmul(wi[bot], TW_IM[tw]));
			pim = wrap16(qmul(wr[bot], TW_IM[tw]) + qmul(wi[bot], TW_RE[tw]));
			wr[bot] = wrap16(wr[top] - pr);
			wi[bot] = wrap16(wi[top] - pim);
			wr[top] = wrap16(wr[top] + pr);
			wi[top] = wrap16(wi[top] + pim);
		end
	end
	for (int n = 0; n < 16; n++) begin
		ref_re[n] = wr[n];
		ref_im[n] = wi[n];
	end
endtask

task automatic clear_stimulus;
	for (int n = 0; n < 16; n++) begin
		stim_re[n] = 0;
		stim_im[n] = 0;
	end
endtask

// one period over the frame, second half mirrors the table
task automatic cosine_stimulus;
	for (int n = 0; n < 16; n++) begin
		stim_re[n] = (n < 8) ? TW_RE[n] : -TW_RE[n - 8];
		stim_im[n] = 0;
	end
endtask

task automatic random_stimulus(input int unsigned lim);
	for (int n = 0; n < 16; n++) begin
		stim_re[n] = int'($urandom_range(2 * lim, 0)) - int'(lim);
		stim_im[n] = int'($urandom_range(2 * lim, 0)) - int'(lim);
	end
endtask

`endif

/* testbench/tb_fft16.sv */
`timescale 1ns/1ps

module tb_fft16;

	localparam int RESET_CYCLES = 10;
	localparam int FRAME_LEN = 8;
	// reset plus 6 tests of 3 frames at 8 cycles, doubled and rounded up
	localparam int MAX_CYCLES = 400;

	logic clk;
	logic rst_n;
	fft_pkg::word_t [15:0] in_re;
	fft_pkg::word_t [15:0] in_im;
	fft_pkg::word_t [15:0] out_re;
	fft_pkg::word_t [15:0] out_im;
	logic fft_done;
	int cycle_count = 0;

	`include "fft_model.svh"

	fft16_top u_dut (
		.i_clk      (clk),
		.i_rst_n    (rst_n),
		.i_re       (in_re),
		.i_im       (in_im),
		.o_re       (out_re),
		.o_im       (out_im),
		.o_fft_done (fft_done)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	//////////////////////////////
	// reporting
	//////////////////////////////
	task automatic end_with_failure;
		$display("TEST FAILED");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string test, input string what,
			input int expv, input int actv);
		$display("CHECK FAILED %s %s: expected %0d, actual %0d", test, what, expv, actv);
		end_with_failure();
	endtask

	task automatic report_problem(input string why);
		$display("%s", why);
		end_with_failure();
	endtask

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= MAX_CYCLES) begin
			report_problem("timeout: no done pulse");
		end
	end

	//////////////////////////////
	// helpers
	//////////////////////////////
	task automatic expect_bin(input string test, input int n, input int exp_re, input int exp_im);
		assert (int'(out_re[n]) == exp_re)
			else report_mismatch(test, $sformatf("bin %0d re", n), exp_re, int'(out_re[n]));
		assert (int'(out_im[n]) == exp_im)
			else report_mismatch(test, $sformatf("bin %0d im", n), exp_im, int'(out_im[n]));
	endtask

	task automatic wait_done;
		@(negedge clk);
		while (!fft_done) begin
			@(negedge clk);
		end
	endtask

	task automatic apply_stimulus;
		fft_pkg::word_t [15:0] re_v;
		fft_pkg::word_t [15:0] im_v;
		for (int n = 0; n < 16; n++) begin
			re_v[n] = 16'(stim_re[n]);
			im_v[n] = 16'(stim_im[n]);
		end
		@(posedge clk);
		in_re <= re_v;
		in_im <= im_v;
	endtask

	// second done pulse is the first frame that saw the new inputs
	task automatic run_frames(input string test);
		apply_stimulus();
		compute_reference();
		wait_done();
		wait_done();
		for (int n = 0; n < 16; n++) begin
			expect_bin(test, n, ref_re[n], ref_im[n]);
		end
	endtask

	//////////////////////////////
	// tests
	//////////////////////////////
	task automatic test_reset;
		for (int c = 0; c < RESET_CYCLES; c++) begin
			@(negedge clk);
			assert (!fft_done) else report_problem("done pulse while in reset");
			for (int n = 0; n < 16; n++) begin
				expect_bin("reset", n, 0, 0);
			end
		end
		@(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		while (!fft_done) begin
			for (int n = 0; n < 16; n++) begin
				expect_bin("startup", n, 0, 0);
			end
			@(negedge clk);
		end
	endtask

	task automatic test_impulse;
		clear_stimulus();
		stim_re[0] = 256;
		run_frames("impulse");
		for (int n = 0; n < 16; n++) begin
			expect_bin("impulse", n, 256, 0);
		end
	endtask

	task automatic test_constant;
		for (int n = 0; n < 16; n++) begin
			stim_re[n] = 16;
			stim_im[n] = 0;
		end
		run_frames("constant");
		for (int n = 0; n < 16; n++) begin
			expect_bin("constant", n, (n == 0) ? 16 * 16 : 0, 0);
		end
	endtask

	task automatic test_cosine;
		cosine_stimulus();
		run_frames("cosine");
		assert (int'(out_re[1]) > 1024 && int'(out_re[15]) > 1024)
			else report_problem("cosine energy missing from bins 1 and 15");
	endtask

	task automatic test_random;
		for (int r = 0; r < 3; r++) begin
			random_stimulus(63);
			run_frames("random");
		end
	endtask

	task automatic test_done_spacing;
		int gap;
		wait_done();
		for (int p = 0; p < 3; p++) begin
			gap = 1;
			@(negedge clk);
			assert (!fft_done) else report_problem("done pulse longer than one cycle");
			while (!fft_done) begin
				@(negedge clk);
				gap++;
			end
			assert (gap == FRAME_LEN) else report_mismatch("done_spacing", "gap", FRAME_LEN, gap);
		end
	endtask

	initial begin
		rst_n = 1'b0;
		in_re = '0;
		in_im = '0;
		void'($urandom(32'hbd72));
		test_reset();
		test_impulse();
		test_constant();
		test_cosine();
		test_random();
		test_done_spacing();
		$display("TEST OK");
		$finish;
	end

endmodule

/* compile.f */
hw/fft_pkg.sv
hw/bfly_if.sv
hw/fft_control.sv
hw/stage_timer.sv
hw/operand_router.sv
hw/bfly_array.sv
hw/result_bank.sv
hw/fft16_top.sv
+incdir+testbench
testbench/tb_fft16.sv

/* run_sim.sh */
#!/bin/sh
# build the fft16 testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_fft16 -f compile.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/Vtb_fft16)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "TEST OK"; then
	exit 0
fi
exit 1
